//--- logic/cop_cprs.sv
// Three async read ports; a write is visible on the reads from the next cycle, no bypass
`timescale 1ns/100ps
module cop_cprs #(
    parameter bit CPR_RESET_ZERO = 1'b1   // Clear all registers on reset
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic [3:0]  crs1_addr,
    input  logic [3:0]  crs2_addr,
    input  logic [3:0]  crs3_addr,
    output logic [31:0] crs1_rdata,
    output logic [31:0] crs2_rdata,
    output logic [31:0] crs3_rdata,
    input  logic [3:0]  crd_wen,      // One enable per byte
    input  logic [3:0]  crd_addr,
    input  logic [31:0] crd_wdata
);

    logic [31:0] regs [16];           // Register array

    // Asynchronous reads
    assign crs1_rdata = regs[crs1_addr];
    assign crs2_rdata = regs[crs2_addr];
    assign crs3_rdata = regs[crs3_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn && CPR_RESET_ZERO) begin
            for (int r = 0; r < 16; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (crd_wen[b]) begin
                    regs[crd_addr][8*b +: 8] <= crd_wdata[8*b +: 8]; // Byte lane b
                end
            end
        end
    end

    // Units must present clean data when they write
    a_wdata_known: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (|crd_wen) |-> !$isunknown(crd_wdata)
    ) else $error("cop_cprs: unknown write data with enable set");

endmodule

//--- logic/cop_fu_if.sv
// Unit bus for one instruction at a time; a unit must drive rd_ben and rd_wdata to zero without idone
`timescale 1ns/100ps
interface cop_fu_if import cop_pkg::*; ();

    logic             ivalid;    // Held high until idone
    cop_sclass_e      subclass;  // Operation select
    cop_pw_e          pw;        // Lane width
    logic [IMM_W-1:0] imm;       // Shift amount
    logic [31:0]      rs1;       // crs1 read data
    logic [31:0]      rs2;       // crs2 read data
    logic [31:0]      rs3;       // crd read data
    logic [31:0]      gpr_rs1;   // CPU register value
    logic             idone;     // One-cycle completion pulse
    logic [3:0]       rd_ben;    // Byte write enables for crd
    logic [31:0]      rd_wdata;  // Write data for crd

    modport unit (
        input  ivalid, subclass, pw, imm, rs1, rs2, rs3, gpr_rs1,
        output idone, rd_ben, rd_wdata
    );

    modport ctrl (
        output ivalid, subclass, pw, imm, rs1, rs2, rs3, gpr_rs1,
        input  idone, rd_ben, rd_wdata
    );

endinterface

//--- logic/cop_idecode.sv
// Purely combinational; fields are sliced even when exception is set and are then meaningless
`timescale 1ns/100ps
module cop_idecode import cop_pkg::*; (
    input  logic [31:0]       encoded,   // Instruction word from the CPU
    output logic              exception, // Illegal instruction
    output cop_class_e        iclass,
    output cop_sclass_e       subclass,
    output cop_pw_e           pw,
    output logic [CREG_W-1:0] crs1,
    output logic [CREG_W-1:0] crs2,
    output logic [CREG_W-1:0] crd,
    output logic [GREG_W-1:0] rd,        // CPU destination for MV2GPR
    output logic [IMM_W-1:0]  imm        // Shift immediate
);

    logic [6:0]        opcode;
    logic [RSVD_W-1:0] rsvd;
    logic [PW_W-1:0]   pw_raw;
    logic              bad_opcode;
    logic              bad_rsvd;
    logic              bad_class;
    logic              bad_pw;

    assign opcode = encoded[6:0];
    assign rsvd   = encoded[F_RSVD_LSB +: RSVD_W];
    assign pw_raw = encoded[F_PW_LSB +: PW_W];

    // Field slicing
    assign iclass   = cop_class_e'(encoded[F_CLASS_LSB +: CLASS_W]);
    assign subclass = cop_sclass_e'(encoded[F_SCLASS_LSB +: SCLASS_W]);
    assign pw       = cop_pw_e'(pw_raw);
    assign crd      = encoded[F_CRD_LSB +: CREG_W];
    assign rd       = encoded[F_CRD_LSB +: GREG_W];   // Overlaps crs1 bit 0
    assign crs1     = encoded[F_CRS1_LSB +: CREG_W];
    assign crs2     = encoded[F_CRS2_LSB +: CREG_W];
    assign imm      = encoded[F_CRS2_LSB +: IMM_W];   // Overlaps bit 29

    // Illegal cases
    assign bad_opcode = opcode != COP_OPCODE;
    assign bad_rsvd   = |rsvd;                        // Top bits reserved
    assign bad_class  = !(iclass inside {PACKED_ARITH, BITWISE, MOVE, MP});

    // Only packed arithmetic looks at pw
    assign bad_pw     = (iclass == PACKED_ARITH) && (pw_raw > PW_W'(PW2));

    assign exception  = bad_opcode || bad_rsvd || bad_class || bad_pw;

endmodule

//--- logic/cop_malu.sv
// Operands must stay stable only in the start cycle; a multiply takes 33 cycles to idone
`timescale 1ns/100ps
module cop_malu import cop_pkg::*; (
    input  logic   g_clk,
    input  logic   g_resetn,
    cop_fu_if.unit fu
);

    logic        busy;                // Operation in flight
    logic [5:0]  step;                // Multiply steps done
    cop_sclass_e op_q;                // Latched operation
    logic [31:0] mcand;               // Multiplicand
    logic [63:0] acc;                 // Product, or sum with carry in bit 32
    logic [32:0] add_sum;
    logic [32:0] part_sum;            // Upper half plus multiplicand
    logic        start;
    logic        start_mul;
    logic        is_mul;
    logic        done;
    logic [31:0] result;

    assign start     = fu.ivalid && !busy;
    assign start_mul = (fu.subclass == MMULL) || (fu.subclass == MMULH);
    assign is_mul    = (op_q == MMULL) || (op_q == MMULH);
    assign done      = busy && (!is_mul || step == 6'd32);

    assign add_sum  = {1'b0, fu.rs1} + {1'b0, fu.rs2} + {32'd0, fu.rs3[0]}; // Carry in from crd
    assign part_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            step <= step + 6'd1;      // Only runs for multiplies
        end
    end

    always_ff @(posedge g_clk) begin
        if (start) begin
            op_q  <= fu.subclass;
            mcand <= fu.rs1;
            acc   <= start_mul ? {32'd0, fu.rs2} : {31'd0, add_sum};
        end else if (busy && is_mul && !done) begin
            acc   <= {part_sum, acc[31:1]};   // Shift-add step
        end
    end

    always_comb begin
        case (op_q)
            MADDC:   result = {31'd0, acc[32]};
            MMULH:   result = acc[63:32];
            default: result = acc[31:0];      // MADD and MMULL
        endcase
    end

    assign fu.idone    = done;
    assign fu.rd_ben   = done ? 4'hf : 4'h0;
    assign fu.rd_wdata = done ? result : '0;

    // Dispatch must wait for the previous operation
    a_no_overlap: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        $rose(fu.ivalid) |-> !busy
    ) else $error("cop_malu: new instruction while busy");

endmodule

//--- logic/cop_palu.sv
// Single cycle, idone follows ivalid; pw codes 5 to 7 give meaningless packed results
`timescale 1ns/100ps
module cop_palu import cop_pkg::*; (
    cop_fu_if.unit fu
);

    logic [5:0]  lane_w;              // Lane width in bits
    logic [31:0] msb_mask;            // Top bit of every lane
    logic [31:0] sll_mask;            // Bits that survive a left shift
    logic [31:0] srl_mask;            // Bits that survive a right shift
    logic [31:0] add_res;
    logic [31:0] sub_res;
    logic [31:0] result;

    assign lane_w = 6'd32 >> fu.pw;

    // Per-bit lane masks
    always_comb begin
        logic [5:0] pos;
        for (int i = 0; i < 32; i++) begin
            pos         = 6'(i) & (lane_w - 6'd1);             // Position inside lane
            msb_mask[i] = pos == (lane_w - 6'd1);
            sll_mask[i] = pos >= {1'b0, fu.imm};
            srl_mask[i] = (pos + {1'b0, fu.imm}) < lane_w;     // Zero once imm >= lane
        end
    end

    // Carries stop at lane tops; top bits fixed up by XOR
    assign add_res = ((fu.rs1 & ~msb_mask) + (fu.rs2 & ~msb_mask))
                   ^ ((fu.rs1 ^ fu.rs2) & msb_mask);

    // Lane top forced to 1 so no borrow leaves a lane
    assign sub_res = ((fu.rs1 | msb_mask) - (fu.rs2 & ~msb_mask))
                   ^ ((fu.rs1 ^ ~fu.rs2) & msb_mask);

    always_comb begin
        case (fu.subclass)
            ADD:     result = add_res;
            SUB:     result = sub_res;
            SLLI:    result = (fu.rs1 << fu.imm) & sll_mask;   // Drop bits from lower lane
            SRLI:    result = (fu.rs1 >> fu.imm) & srl_mask;   // Drop bits from upper lane
            AND:     result = fu.rs1 & fu.rs2;
            OR:      result = fu.rs1 | fu.rs2;
            XOR:     result = fu.rs1 ^ fu.rs2;
            NOT:     result = ~fu.rs1;
            MV2COP:  result = fu.gpr_rs1;                      // CPU value into crd
            MV2GPR:  result = fu.rs1;                          // Goes to the CPU instead
            default: result = '0;
        endcase
    end

    assign fu.idone    = fu.ivalid;
    assign fu.rd_wdata = fu.ivalid ? result : '0;

    // MV2GPR leaves the register file alone
    assign fu.rd_ben   = (fu.ivalid && fu.subclass != MV2GPR) ? 4'hf : 4'h0;

endmodule

//--- logic/cop_pkg.sv
// Shared encodings for the co-processor; class codes 0, 5, 6, 7 and pw codes 5 to 7 are illegal
package cop_pkg;

    localparam logic [6:0] COP_OPCODE = 7'h2b; // Major opcode of every COP instruction

    localparam int F_CLASS_LSB  = 7;   // Class in bits 9..7
    localparam int F_SCLASS_LSB = 10;  // Subclass in bits 13..10
    localparam int F_PW_LSB     = 14;  // Pack width in bits 16..14
    localparam int F_CRD_LSB    = 17;  // Also the CPU rd field
    localparam int F_CRS1_LSB   = 21;
    localparam int F_CRS2_LSB   = 25;  // Also the shift immediate
    localparam int F_RSVD_LSB   = 30;  // Must be zero

    localparam int CLASS_W  = 3;
    localparam int SCLASS_W = 4;
    localparam int PW_W     = 3;
    localparam int CREG_W   = 4;       // COP register index
    localparam int GREG_W   = 5;       // CPU register index
    localparam int IMM_W    = 5;
    localparam int RSVD_W   = 2;

    typedef enum logic [CLASS_W-1:0] {
        PACKED_ARITH = 3'd1,
        BITWISE      = 3'd2,
        MOVE         = 3'd3,
        MP           = 3'd4
    } cop_class_e;

    typedef enum logic [SCLASS_W-1:0] {
        ADD, SUB, SLLI, SRLI,          // Packed arithmetic
        AND, OR, XOR, NOT,             // Bitwise
        MV2GPR, MV2COP,                // Moves
        MADD, MADDC, MMULL, MMULH      // Multi-precision
    } cop_sclass_e;

    typedef enum logic [2:0] {SUCCESS = 3'd0, BAD_INS = 3'd1} cop_result_e;

    typedef enum logic [1:0] {IDLE, WAITING, EXECUTING, FINISHED} cop_fsm_e;

    // Lane width is 32 >> pw
    typedef enum logic [PW_W-1:0] {PW32, PW16, PW8, PW4, PW2} cop_pw_e;

endpackage

//--- logic/cop_top.sv
// CPU must hold cpu_insn_enc and cpu_rs1 from accept until cop_insn_rsp; one instruction in flight
`timescale 1ns/100ps
module cop_top import cop_pkg::*; #(
    parameter bit CPR_RESET_ZERO = 1'b1
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        cpu_insn_req,   // Instruction request
    output logic        cop_insn_ack,   // Ready to accept
    input  logic [31:0] cpu_insn_enc,
    input  logic [31:0] cpu_rs1,
    output logic        cop_wen,        // GPR write for MV2GPR
    output logic [4:0]  cop_waddr,
    output logic [31:0] cop_wdata,
    output logic [2:0]  cop_result,
    output logic        cop_insn_rsp,   // Instruction finished
    input  logic        cpu_insn_ack    // Response taken
);

    logic              id_exception;
    cop_class_e        id_class;
    cop_sclass_e       id_subclass;
    cop_pw_e           id_pw;
    logic [CREG_W-1:0] id_crs1;
    logic [CREG_W-1:0] id_crs2;
    logic [CREG_W-1:0] id_crd;
    logic [GREG_W-1:0] id_rd;
    logic [IMM_W-1:0]  id_imm;
    logic [31:0]       crs1_rdata;
    logic [31:0]       crs2_rdata;
    logic [31:0]       crs3_rdata;
    cop_fsm_e          state;
    cop_fsm_e          n_state;
    logic              n_ack;
    logic              n_rsp;
    logic              insn_accept;
    logic              insn_retired;
    logic              insn_valid;
    logic              bad_finish;      // Illegal ones finish on accept
    logic              insn_finish;

    cop_fu_if palu_bus ();
    cop_fu_if malu_bus ();

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;
    assign insn_valid   = insn_accept || state == EXECUTING;
    assign bad_finish   = insn_accept && id_exception;
    assign insn_finish  = palu_bus.idone || malu_bus.idone || bad_finish;

    // Dispatch by class
    assign palu_bus.ivalid = insn_valid && !id_exception && id_class != MP;
    assign malu_bus.ivalid = insn_valid && !id_exception && id_class == MP;

    assign palu_bus.subclass = id_subclass;
    assign palu_bus.pw       = id_pw;
    assign palu_bus.imm      = id_imm;
    assign palu_bus.rs1      = crs1_rdata;
    assign palu_bus.rs2      = crs2_rdata;
    assign palu_bus.rs3      = crs3_rdata;
    assign palu_bus.gpr_rs1  = cpu_rs1;
    assign malu_bus.subclass = id_subclass;
    assign malu_bus.pw       = id_pw;
    assign malu_bus.imm      = id_imm;
    assign malu_bus.rs1      = crs1_rdata;
    assign malu_bus.rs2      = crs2_rdata;
    assign malu_bus.rs3      = crs3_rdata;
    assign malu_bus.gpr_rs1  = cpu_rs1;

    always_comb begin
        n_state = state;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            IDLE: begin
                n_state = WAITING;
                n_ack   = 1'b1;
            end
            WAITING: begin
                if (insn_accept && insn_finish) begin
                    n_state = FINISHED;          // Same-cycle finish
                    n_rsp   = 1'b1;
                end else if (insn_accept) begin
                    n_state = EXECUTING;
                end else begin
                    n_ack   = 1'b1;
                end
            end
            EXECUTING: begin
                if (insn_finish) begin
                    n_state = FINISHED;
                    n_rsp   = 1'b1;
                end
            end
            default: begin                       // FINISHED
                if (insn_retired) begin
                    n_state = WAITING;
                    n_ack   = 1'b1;
                end else begin
                    n_rsp   = 1'b1;              // Hold until CPU takes it
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
        end else begin
            state        <= n_state;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
            if (insn_finish) begin
                cop_wen  <= !id_exception && id_class == MOVE && id_subclass == MV2GPR;
            end
        end
    end

    // Response payload captured on finish
    always_ff @(posedge g_clk) begin
        if (insn_finish) begin
            cop_waddr  <= id_rd;
            cop_wdata  <= palu_bus.rd_wdata;     // crs1 for MV2GPR
            cop_result <= id_exception ? BAD_INS : SUCCESS;
        end
    end

    cop_idecode idecode_i (
        .encoded(cpu_insn_enc), .exception(id_exception), .iclass(id_class),
        .subclass(id_subclass), .pw(id_pw), .crs1(id_crs1), .crs2(id_crs2),
        .crd(id_crd), .rd(id_rd), .imm(id_imm)
    );

    cop_cprs #(.CPR_RESET_ZERO(CPR_RESET_ZERO)) cprs_i (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .crs1_addr(id_crs1), .crs2_addr(id_crs2), .crs3_addr(id_crd),  // crs3 is crd
        .crs1_rdata(crs1_rdata), .crs2_rdata(crs2_rdata), .crs3_rdata(crs3_rdata),
        .crd_wen(palu_bus.rd_ben | malu_bus.rd_ben), .crd_addr(id_crd),
        .crd_wdata(palu_bus.rd_wdata | malu_bus.rd_wdata)               // Idle units give zero
    );

    cop_palu palu_i (.fu(palu_bus.unit));

    cop_malu malu_i (.g_clk(g_clk), .g_resetn(g_resetn), .fu(malu_bus.unit));

    // Response and payload held, ack kept low, until the CPU takes it
    a_rsp_hold: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp && !cop_insn_ack
            && $stable({cop_result, cop_wen, cop_waddr, cop_wdata})
    ) else $error("cop_top: response changed before the CPU took it");

    // One finish source, and only for an instruction in flight
    a_one_finish: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        insn_finish |-> insn_valid && $onehot({palu_bus.idone, malu_bus.idone, bad_finish})
    ) else $error("cop_top: bad finish");

    a_finish_bound: assert property (
        @(posedge g_clk) disable iff (!g_resetn) insn_accept |-> ##[0:33] insn_finish
    ) else $error("cop_top: instruction never finished");

endmodule

//--- sim/cop_checker.sv
// Watches the CPU port only; the register model assumes registers clear on reset
`timescale 1ns/100ps
module cop_checker import cop_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        cpu_insn_req,
    input  logic        cop_insn_ack,
    input  logic [31:0] cpu_insn_enc,
    input  logic [31:0] cpu_rs1,
    input  logic        cop_wen,
    input  logic [4:0]  cop_waddr,
    input  logic [31:0] cop_wdata,
    input  logic [2:0]  cop_result,
    input  logic        cop_insn_rsp,
    input  logic        cpu_insn_ack,
    output int          error_count,     // Mismatches and protocol faults
    output int          retire_count     // Responses taken by the CPU
);

    logic [31:0] model [16];             // Expected register file
    logic        pending;                // Accepted, not yet retired
    logic        held;                   // Response seen without ack last edge
    logic [2:0]  exp_result;
    logic        exp_wen;
    logic [4:0]  exp_waddr;
    logic [31:0] exp_wdata;
    logic [2:0]  last_result;            // Outputs at previous edge
    logic        last_wen;
    logic [4:0]  last_waddr;
    logic [31:0] last_wdata;

    initial begin
        error_count  = 0;
        retire_count = 0;
        pending      = 1'b0;
        held         = 1'b0;
        for (int r = 0; r < 16; r++) begin
            model[r] = '0;
        end
    end

    // Lane by lane on a 64-bit scratch value
    function automatic logic [31:0] lane_result(input cop_sclass_e op, input logic [31:0] a,
                                                input logic [31:0] b, input int lane_w,
                                                input int shamt);
        logic [63:0] mask;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        logic [31:0] res;
        res  = '0;
        mask = (64'd1 << lane_w) - 64'd1;
        for (int k = 0; k < 32; k += lane_w) begin
            x = (a >> k) & mask;
            y = (b >> k) & mask;
            case (op)
                ADD:     r = x + y;
                SUB:     r = x - y;                                  // Wraps inside lane
                SLLI:    r = (shamt >= lane_w) ? 64'd0 : x << shamt;
                default: r = (shamt >= lane_w) ? 64'd0 : x >> shamt;  // SRLI
            endcase
            res = res | 32'((r & mask) << k);
        end
        return res;
    endfunction

    // Work out the response and update the model at accept
    task automatic predict_response(input logic [31:0] enc, input logic [31:0] gpr);
        logic [2:0]  cls;
        logic [2:0]  pw;
        logic [3:0]  crd;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] wide;
        logic        legal;
        cop_sclass_e sub;
        cls   = enc[9:7];
        sub   = cop_sclass_e'(enc[13:10]);
        pw    = enc[16:14];
        crd   = enc[20:17];
        a     = model[enc[24:21]];
        b     = model[enc[28:25]];
        legal = enc[6:0] == COP_OPCODE && enc[31:30] == 2'b00 && cls >= 3'd1 && cls <= 3'd4
                && !(cls == 3'd1 && pw > 3'd4);              // pw only matters when packed
        exp_result = legal ? SUCCESS : BAD_INS;
        exp_wen    = 1'b0;
        exp_waddr  = enc[21:17];
        exp_wdata  = '0;
        if (legal) begin
            case (sub)
                ADD, SUB, SLLI, SRLI: model[crd] = lane_result(sub, a, b, 32 >> pw, enc[29:25]);
                AND:    model[crd] = a & b;
                OR:     model[crd] = a | b;
                XOR:    model[crd] = a ^ b;
                NOT:    model[crd] = ~a;
                MV2COP: model[crd] = gpr;
                MV2GPR: begin
                    exp_wen   = 1'b1;
                    exp_wdata = a;
                end
                MADD, MADDC: begin
                    wide = {32'd0, a} + {32'd0, b} + {63'd0, model[crd][0]}; // Carry in from crd
                    model[crd] = (sub == MADD) ? wide[31:0] : {31'd0, wide[32]};
                end
                MMULL, MMULH: begin
                    wide = {32'd0, a} * {32'd0, b};
                    model[crd] = (sub == MMULL) ? wide[31:0] : wide[63:32];
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] gotv);
        if (gotv !== expv) begin
            $display("[ERROR] %s: expected %h, got %h", name, expv, gotv);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Protocol failure at %0t ns: %s", $time, what);
        error_count++;
    endtask

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            if (cop_insn_ack === 1'b1 || cop_insn_rsp === 1'b1 || cop_wen === 1'b1) begin
                note_failure("handshake output high during reset");
            end
            pending = 1'b0;
            held    = 1'b0;
        end else begin
            if (cop_insn_ack && cop_insn_rsp) note_failure("ack and response high together");
            if (cop_insn_ack && pending) note_failure("ack high before retirement");
            if (cop_insn_rsp && !pending) note_failure("response with no accepted instruction");
            if (held && (cop_result !== last_result || cop_wen !== last_wen
                         || cop_waddr !== last_waddr || cop_wdata !== last_wdata)) begin
                note_failure("response outputs changed while waiting for the CPU");
            end
            if (cop_insn_rsp && cpu_insn_ack && pending) begin // Retirement
                check_value("cop_result", 32'(exp_result), 32'(cop_result));
                check_value("cop_wen", 32'(exp_wen), 32'(cop_wen));
                if (exp_wen) begin
                    check_value("cop_waddr", 32'(exp_waddr), 32'(cop_waddr));
                    check_value("cop_wdata", exp_wdata, cop_wdata);
                end
                retire_count++;
                pending = 1'b0;
            end
            if (cpu_insn_req && cop_insn_ack) begin         // Accept
                predict_response(cpu_insn_enc, cpu_rs1);
                pending = 1'b1;
            end
            held        = cop_insn_rsp && !cpu_insn_ack;
            last_result = cop_result;
            last_wen    = cop_wen;
            last_waddr  = cop_waddr;
            last_wdata  = cop_wdata;
        end
    end

endmodule

//--- sim/cop_tb.sv
// Random stimulus from a fixed seed; one instruction at a time, CPU holds inputs until retirement
`timescale 1ns/100ps
module cop_tb import cop_pkg::*; ();

    localparam int  RANDOM_INSNS = 400;
    localparam int  WATCHDOG_NS  = 900 * 40 * 100;   // Instructions x cycles x period
    localparam time DRIVE_DELAY  = 10;               // After the rising edge

    logic        g_clk;
    logic        g_resetn;
    logic        cpu_insn_req;
    logic        cop_insn_ack;
    logic [31:0] cpu_insn_enc;
    logic [31:0] cpu_rs1;
    logic        cop_wen;
    logic [4:0]  cop_waddr;
    logic [31:0] cop_wdata;
    logic [2:0]  cop_result;
    logic        cop_insn_rsp;
    logic        cpu_insn_ack;
    integer      seed;
    int          issued;
    int          error_count;
    int          retire_count;
    logic [31:0] enc;
    logic [31:0] r;

    cop_top #(.CPR_RESET_ZERO(1'b1)) dut_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cop_insn_ack(cop_insn_ack), .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1),
        .cop_wen(cop_wen), .cop_waddr(cop_waddr), .cop_wdata(cop_wdata),
        .cop_result(cop_result), .cop_insn_rsp(cop_insn_rsp), .cpu_insn_ack(cpu_insn_ack)
    );

    cop_checker checker_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cop_insn_ack(cop_insn_ack), .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1),
        .cop_wen(cop_wen), .cop_waddr(cop_waddr), .cop_wdata(cop_wdata),
        .cop_result(cop_result), .cop_insn_rsp(cop_insn_rsp), .cpu_insn_ack(cpu_insn_ack),
        .error_count(error_count), .retire_count(retire_count)
    );

    always #50 g_clk = ~g_clk;                       // 100 ns period

    // Immediate field also carries crs2
    function automatic logic [31:0] encode(input logic [2:0] cls, input logic [3:0] sub,
                                           input logic [2:0] pw, input logic [3:0] crd,
                                           input logic [3:0] crs1, input logic [4:0] imm);
        return {2'b00, imm, crs1, crd, pw, sub, cls, COP_OPCODE};
    endfunction

    task automatic next_cycle();
        @(posedge g_clk);
        #(DRIVE_DELAY);
    endtask

    // Full CPU handshake for one instruction
    task automatic run_insn(input logic [31:0] insn, input logic [31:0] gpr);
        int delay;
        cpu_insn_req = 1'b1;
        cpu_insn_enc = insn;
        cpu_rs1      = gpr;
        while (!cop_insn_ack) next_cycle();
        next_cycle();                                // Accepting edge
        cpu_insn_req = 1'b0;
        while (!cop_insn_rsp) next_cycle();
        delay = $unsigned($random(seed)) % 4;        // CPU back-pressure
        repeat (delay) next_cycle();
        cpu_insn_ack = 1'b1;
        next_cycle();
        cpu_insn_ack = 1'b0;
        issued++;
    endtask

    task automatic make_legal(output logic [31:0] insn);
        logic [31:0] x;
        logic [2:0]  cls;
        logic [3:0]  sub;
        logic [2:0]  pw;
        x  = $random(seed);
        pw = x[6:4];                                 // Ignored outside packed class
        case (x[1:0])
            2'd0: begin
                cls = PACKED_ARITH;
                sub = {2'b00, x[3:2]};               // ADD to SRLI
                pw  = x[6:4] % 5;
            end
            2'd1: begin
                cls = BITWISE;
                sub = 4'(AND) + x[3:2];
            end
            2'd2: begin
                cls = MOVE;
                sub = x[2] ? MV2COP : MV2GPR;
            end
            default: begin
                cls = MP;
                sub = 4'(MADD) + x[3:2];
            end
        endcase
        insn = encode(cls, sub, pw, x[10:7], x[14:11], x[19:15]);
    endtask

    // Corrupt one field of a legal encoding
    task automatic make_illegal(output logic [31:0] insn);
        logic [31:0] x;
        make_legal(insn);
        x = $random(seed);
        case (x[1:0])
            2'd0: insn[6:0]   = (x[8:2] == COP_OPCODE) ? ~COP_OPCODE : x[8:2];
            2'd1: insn[31:30] = (x[3:2] == 2'b00) ? 2'b11 : x[3:2];
            2'd2: insn[9:7]   = (x[3:2] == 2'b00) ? 3'd0 : 3'd4 + x[3:2];  // 0, 5, 6 or 7
            default: begin
                insn[9:7]   = PACKED_ARITH;
                insn[16:14] = 3'd5 + (x[3:2] % 3);
            end
        endcase
    endtask

    task automatic read_back(input logic [3:0] creg);
        logic [31:0] x;
        x = $random(seed);
        run_insn(encode(MOVE, MV2GPR, x[2:0], x[6:3], creg, x[11:7]), $random(seed));
    endtask

    initial begin
        seed         = 32'h8bfc_1a44;
        issued       = 0;
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        repeat (2) @(posedge g_clk);
        #(DRIVE_DELAY);
        g_resetn = 1'b1;
        for (int i = 0; i < 16; i++) begin            // Load and check every register
            r = $random(seed);
            run_insn(encode(MOVE, MV2COP, r[2:0], 4'(i), r[6:3], r[11:7]), $random(seed));
            read_back(4'(i));
        end
        for (int n = 0; n < RANDOM_INSNS; n++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) make_illegal(enc);    // About 1 in 16
            else make_legal(enc);
            run_insn(enc, $random(seed));
            r = $random(seed);
            read_back(r[3:0]);
        end
        repeat (4) next_cycle();
        if (retire_count != issued) begin
            $display("Retired %0d instructions, but %0d were issued", retire_count, issued);
        end
        $display("Issued %0d, retired %0d, errors %0d", issued, retire_count, error_count);
        if (error_count == 0 && retire_count == issued) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d instructions issued", WATCHDOG_NS, issued);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog.f
logic/cop_pkg.sv
logic/cop_fu_if.sv
logic/cop_idecode.sv
logic/cop_cprs.sv
logic/cop_palu.sv
logic/cop_malu.sv
logic/cop_top.sv
sim/cop_checker.sv
sim/cop_tb.sv
